/* include/mmio_params.svh */
`ifndef MMIO_PARAMS_SVH
`define MMIO_PARAMS_SVH

// ********************
// Peripheral byte addresses
// ********************

// System control register.
`define MMIO_SYSCON_ADDR   32'hFF00_0004

// SPI data register. The status register is at +4.
`define MMIO_SPI_ADDR      32'hFF00_0008

`define MMIO_MTIME_ADDR    32'hFF00_0080 // The mtime low word. The high word is at +4.
`define MMIO_MTIMECMP_ADDR 32'hFF00_0088 // The mtimecmp low word. The high word is at +4.

// ********************
// Timer
// ********************

`define MMIO_TIMER_DIV     4 // Clock cycles per mtime tick.

`endif

/* mmioSubsystem.f */
+incdir+include
source/mmio_pkg.sv
source/busArbiter.sv
source/machineTimer.sv
source/spiController.sv
source/sysControl.sv
source/mmioSubsystem.sv
sim/mmioSubsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mmioSubsystem_tb -f mmioSubsystem.f -o simv

output=$(./obj_dir/simv)
echo "$output"

if echo "$output" | grep -q "^Verification passed$"; then
    exit 0
fi
exit 1

/* sim/mmioSubsystem_tb.sv */
`include "mmio_params.svh"

module mmioSubsystem_tb import mmio_pkg::*; ();

    localparam int TimeoutCycles = 3000;

    logic     clk = 1'b0;
    logic     rst;
    busReq_t  req0;
    busReq_t  req1;
    logic     accept0_o;
    logic     accept1_o;
    busResp_t resp0_o;
    busResp_t resp1_o;
    logic     timerIrq_o;
    logic     reboot_o;
    logic     powerOff_o;
    logic     spiCs_o;
    logic     spiClk_o;
    logic     spiMosi_o;
    wire      spiMiso;

    integer      seed = 32'h012d_0542;
    int          errors = 0;
    int          cycle = 0;
    bit          lastGranted = 1'b1; // Master 0 wins the first contest.
    logic [31:0] exp0[$];
    logic [31:0] exp1[$];
    int          tol0[$];
    int          tol1[$];
    int          spiLen = 0;
    int          spiPulses = 0;
    int          csRiseCount = 0;
    int          lastCsRise = 0;
    int          rebootPulses = 0;
    int          powerOffPulses = 0;
    logic        prevCs = 1'b1;
    logic        prevSpiClk = 1'b0;

    assign spiMiso = spiMosi_o; // Loopback.

    mmioSubsystem dut_i (
        .clk        (clk),
        .rst        (rst),
        .req0_i     (req0),
        .req1_i     (req1),
        .accept0_o  (accept0_o),
        .accept1_o  (accept1_o),
        .resp0_o    (resp0_o),
        .resp1_o    (resp1_o),
        .timerIrq_o (timerIrq_o),
        .reboot_o   (reboot_o),
        .powerOff_o (powerOff_o),
        .spiCs_o    (spiCs_o),
        .spiClk_o   (spiClk_o),
        .spiMosi_o  (spiMosi_o),
        .spiMiso_i  (spiMiso)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == TimeoutCycles) begin
            $display("ERROR: the run did not finish within %0d cycles", TimeoutCycles);
            $display("Errors: %0d", errors + 1);
            $display("Verification failed");
            $finish;
        end
    end

    // ********************
    // Checking helpers
    // ********************

    function automatic logic [31:0] maskedMerge(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] mask);
        logic [31:0] bits;
        bits = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (old & ~bits) | (data & bits);
    endfunction

    task automatic compareValue(input string name, input int got, input int expv);
        assert (got == expv) else begin
            errors++;
            $display("MISMATCH at time %0t: %s expected %0d, got %0d", $time, name, expv, got);
        end
    endtask

    task automatic confirm(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("ERROR at time %0t: %s", $time, what);
        end
    endtask

    task automatic pushExpect(input bit m, input logic [31:0] expv, input int tol);
        if (m) begin
            exp1.push_back(expv);
            tol1.push_back(tol);
        end else begin
            exp0.push_back(expv);
            tol0.push_back(tol);
        end
    endtask

    task automatic takeResponse(input bit m, input logic [31:0] data);
        logic [31:0] expv;
        int          tol;
        bit          empty;
        empty = m ? (exp1.size() == 0) : (exp0.size() == 0);
        assert (!empty) else begin
            errors++;
            $display("ERROR at time %0t: response on master %0d with no read pending", $time, m);
        end
        if (!empty) begin
            expv = m ? exp1.pop_front() : exp0.pop_front();
            tol  = m ? tol1.pop_front() : tol0.pop_front();
            assert (data - expv <= tol) else begin // The unsigned difference wraps below expv.
                errors++;
                $display("MISMATCH at time %0t: resp%0d_o.rdata expected %h, got %h",
                         $time, m, expv, data);
            end
        end
    endtask

    // Responses, SPI pins and system pulses are all sampled mid-cycle.
    always @(negedge clk) begin
        if (!rst) begin
            if (resp0_o.valid) takeResponse(1'b0, resp0_o.rdata);
            if (resp1_o.valid) takeResponse(1'b1, resp1_o.rdata);
            if (reboot_o) rebootPulses++;
            if (powerOff_o) powerOffPulses++;
            confirm(!(spiCs_o && spiClk_o), "SPI clock is high while chip select is high");
            if (prevCs && !spiCs_o) spiPulses = 0;
            if (!spiCs_o && spiClk_o && !prevSpiClk) spiPulses++;
            if (!prevCs && spiCs_o) begin
                csRiseCount++;
                lastCsRise = cycle - 1;
                compareValue("SPI clock pulses", spiPulses, spiLen);
            end
        end
        prevCs     = spiCs_o;
        prevSpiClk = spiClk_o;
    end

    // ********************
    // Stimulus
    // ********************

    task automatic issueRequest(input bit m, input busOp_t reqOp, input logic [31:0] byteAddr,
                                input logic [3:0] wmask, input logic [31:0] wdata,
                                output int accEdge);
        busReq_t req;
        bit      accepted;
        req = '{op: reqOp, addr: byteAddr[31:2], wmask: wmask, wdata: wdata};
        @(posedge clk);
        if (m) req1 <= req;
        else req0 <= req;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = m ? accept1_o : accept0_o;
        end
        @(posedge clk);
        accEdge     = cycle;
        lastGranted = m;
        if (m) req1.op <= OP_NONE;
        else req0.op <= OP_NONE;
    endtask

    task automatic expectRead(input bit m, input logic [31:0] byteAddr, input logic [31:0] expv,
                              output int accEdge);
        issueRequest(m, OP_READ, byteAddr, 4'h0, 32'h0, accEdge);
        pushExpect(m, expv, 0);
    endtask

    task automatic waitDrained();
        while (exp0.size() != 0 || exp1.size() != 0) @(negedge clk);
    endtask

    task automatic waitTransfers(input int count);
        while (csRiseCount < count) @(negedge clk);
    endtask

    initial begin
        int          acc0;
        int          acc1;
        int          accW;
        int          accF;
        int          accC;
        int          wEdge;
        int          k;
        int          riseEdge;
        int          doneCount;
        bit          prevLast;
        logic [31:0] wVal;
        logic [31:0] target;
        logic [31:0] word;
        logic [31:0] word2;

        req0 = '0;
        req1 = '0;
        rst  = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        confirm(accept0_o && accept1_o, "accept is not high after reset");
        confirm(!resp0_o.valid && !resp1_o.valid, "a response is valid after reset");
        confirm(spiCs_o && !spiClk_o, "SPI pins are not idle after reset");
        confirm(!timerIrq_o && !reboot_o && !powerOff_o, "an output pulse is active after reset");
        expectRead(1'b0, `MMIO_MTIMECMP_ADDR + 32'd4, 32'hFFFF_FFFF, acc0);
        expectRead(1'b1, `MMIO_MTIME_ADDR + 32'd4, 32'h0, acc1);
        waitDrained();

        // Timer count after a write. The divider phase allows one tick of slack.
        wVal = $random(seed) & 32'h7FFF_FFFF;
        issueRequest(1'b0, OP_WRITE, `MMIO_MTIME_ADDR, 4'hF, wVal, accW);
        wEdge = accW + 1;
        repeat (9) @(posedge clk);
        issueRequest(1'b0, OP_READ, `MMIO_MTIME_ADDR, 4'h0, 32'h0, acc0);
        pushExpect(1'b0, wVal + (acc0 - wEdge) / `MMIO_TIMER_DIV, 1);
        waitDrained();

        // Compare value built up with byte masks.
        k      = (cycle - wEdge) / `MMIO_TIMER_DIV + 20;
        target = wVal + k;
        issueRequest(1'b0, OP_WRITE, `MMIO_MTIMECMP_ADDR, 4'b0011, target, acc0);
        expectRead(1'b0, `MMIO_MTIMECMP_ADDR, maskedMerge(32'hFFFF_FFFF, target, 4'b0011), acc0);
        issueRequest(1'b0, OP_WRITE, `MMIO_MTIMECMP_ADDR, 4'b1100, target, acc0);
        expectRead(1'b0, `MMIO_MTIMECMP_ADDR, target, acc0);
        issueRequest(1'b0, OP_WRITE, `MMIO_MTIMECMP_ADDR + 32'd4, 4'b0101, 32'h0, acc0);
        expectRead(1'b0, `MMIO_MTIMECMP_ADDR + 32'd4,
                   maskedMerge(32'hFFFF_FFFF, 32'h0, 4'b0101), acc0);
        issueRequest(1'b0, OP_WRITE, `MMIO_MTIMECMP_ADDR + 32'd4, 4'b1010, 32'h0, accF);
        confirm(!timerIrq_o, "timer interrupt is high before mtimecmp is complete");
        riseEdge = -1;
        while (riseEdge < 0) begin
            @(negedge clk);
            if (timerIrq_o) riseEdge = cycle - 1;
        end
        confirm(riseEdge > accF, "timer interrupt rose before the last mtimecmp write");
        confirm(riseEdge >= wEdge + 4 * k - 3 && riseEdge <= wEdge + 4 * k,
                "timer interrupt rose at a tick other than mtime reaching mtimecmp");
        waitDrained();

        // Contested reads. The loser goes on the next edge.
        repeat (4) begin
            prevLast = lastGranted;
            fork
                expectRead(1'b0, `MMIO_MTIMECMP_ADDR, target, acc0);
                expectRead(1'b1, `MMIO_MTIMECMP_ADDR + 32'd4, 32'h0, acc1);
            join
            confirm((acc0 < acc1) != !prevLast, "arbiter granted the last winner first");
            confirm(acc0 - acc1 == 1 || acc1 - acc0 == 1, "contested reads were not back to back");
        end
        waitDrained();

        // ********************
        // SPI transfers
        // ********************

        word   = $random(seed);
        spiLen = 8;
        issueRequest(1'b0, OP_WRITE, `MMIO_SPI_ADDR, 4'b0001, word, accC);
        waitTransfers(1);
        expectRead(1'b0, `MMIO_SPI_ADDR + 32'd4, 32'h0000_0100, acc0);
        expectRead(1'b0, `MMIO_SPI_ADDR, {24'h0, word[7:0]}, acc0);
        expectRead(1'b0, `MMIO_SPI_ADDR + 32'd4, 32'h0, acc0);
        waitDrained();

        word   = $random(seed);
        spiLen = 32;
        issueRequest(1'b0, OP_WRITE, `MMIO_SPI_ADDR, 4'b1111, word, accC);
        waitTransfers(2);
        expectRead(1'b0, `MMIO_SPI_ADDR + 32'd4, 32'h0000_0100, acc0);
        expectRead(1'b0, `MMIO_SPI_ADDR, word, acc0);
        expectRead(1'b0, `MMIO_SPI_ADDR + 32'd4, 32'h0, acc0);
        waitDrained();

        // Master 1 writes while master 0's transfer runs.
        word      = $random(seed);
        word2     = $random(seed);
        spiLen    = 8;
        doneCount = csRiseCount;
        fork
            issueRequest(1'b0, OP_WRITE, `MMIO_SPI_ADDR, 4'b0001, word, accC);
            begin
                @(posedge clk);
                issueRequest(1'b1, OP_WRITE, `MMIO_SPI_ADDR, 4'b0001, word2, acc1);
            end
        join
        confirm(lastCsRise > accC && acc1 > lastCsRise,
                "second SPI write was accepted while the SPI was busy");
        waitTransfers(doneCount + 2);
        expectRead(1'b1, `MMIO_SPI_ADDR, {24'h0, word2[7:0]}, acc1);
        expectRead(1'b1, `MMIO_SPI_ADDR + 32'd4, 32'h0, acc1);
        waitDrained();

        // ********************
        // System control and unmapped reads
        // ********************

        issueRequest(1'b0, OP_WRITE, `MMIO_SYSCON_ADDR, 4'b0001, 32'h77, acc0);
        repeat (3) @(negedge clk);
        compareValue("reboot_o pulses", rebootPulses, 1);
        compareValue("powerOff_o pulses", powerOffPulses, 0);
        issueRequest(1'b1, OP_WRITE, `MMIO_SYSCON_ADDR, 4'b0001, 32'h55, acc1);
        repeat (3) @(negedge clk);
        compareValue("reboot_o pulses", rebootPulses, 1);
        compareValue("powerOff_o pulses", powerOffPulses, 1);
        issueRequest(1'b0, OP_WRITE, `MMIO_SYSCON_ADDR, 4'b0001, 32'h5A, acc0);
        repeat (3) @(negedge clk);
        compareValue("reboot_o pulses", rebootPulses, 1);
        compareValue("powerOff_o pulses", powerOffPulses, 1);

        expectRead(1'b0, 32'hFF00_0100, 32'h0, acc0);
        expectRead(1'b1, `MMIO_SYSCON_ADDR, 32'h0, acc1);
        waitDrained();
        repeat (2) @(negedge clk);

        $display("Checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* source/busArbiter.sv */
`include "mmio_params.svh"

module busArbiter import mmio_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  busReq_t  req0_i,
    input  busReq_t  req1_i,
    input  logic     spiBusy_i,
    output logic     accept0_o,
    output logic     accept1_o,
    output busSlot_t bus_o
);

    logic spiHold;
    logic blocked0;
    logic blocked1;
    logic want0;
    logic want1;
    logic grant0;
    logic grant1;
    logic rrPtr; // Master that won last time.

    function automatic logic isSpiWrite(input busReq_t req);
        return (req.op == OP_WRITE) && ({req.addr, 2'b00} == `MMIO_SPI_ADDR);
    endfunction

    // A write already on the slot has not reached the SPI yet.
    assign spiHold  = spiBusy_i || isSpiWrite(bus_o.req);
    assign blocked0 = spiHold && isSpiWrite(req0_i);
    assign blocked1 = spiHold && isSpiWrite(req1_i);

    assign want0 = (req0_i.op != OP_NONE) && !blocked0;
    assign want1 = (req1_i.op != OP_NONE) && !blocked1;

    assign grant1 = want1 && (!want0 || !rrPtr);
    assign grant0 = want0 && !grant1;

    assign accept0_o = !blocked0 && !grant1;
    assign accept1_o = !blocked1 && !grant0;

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_o.req.op <= OP_NONE;
            bus_o.src    <= 1'b0;
            rrPtr        <= 1'b1; // Master 0 goes first.
        end else if (grant0) begin
            bus_o <= '{req: req0_i, src: 1'b0};
            rrPtr <= 1'b0;
        end else if (grant1) begin
            bus_o <= '{req: req1_i, src: 1'b1};
            rrPtr <= 1'b1;
        end else begin
            bus_o.req.op <= OP_NONE;
        end
    end

endmodule

/* source/machineTimer.sv */
`include "mmio_params.svh"

module machineTimer import mmio_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  busSlot_t bus_i,
    output busResp_t resp_o,
    output logic     timerIrq_o
);

    localparam int DivW = $clog2(`MMIO_TIMER_DIV + 1);
    localparam logic [DivW-1:0] DivLast = DivW'(`MMIO_TIMER_DIV - 1);

    logic [DivW-1:0] divCnt;
    logic [63:0]     mtime;
    logic [63:0]     mtimecmp;
    logic            tick;
    logic [31:0]     byteAddr;
    logic            isRead;
    logic            isWrite;
    busResp_t        respNext;

    function automatic logic [31:0] mergeBytes(input logic [31:0] old,
                                               input logic [31:0] data,
                                               input logic [3:0]  mask);
        logic [31:0] result;
        result = old;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) result[8*i +: 8] = data[8*i +: 8];
        end
        return result;
    endfunction

    assign byteAddr   = {bus_i.req.addr, 2'b00};
    assign isRead     = bus_i.req.op == OP_READ;
    assign isWrite    = bus_i.req.op == OP_WRITE;
    assign tick       = divCnt == '0;
    assign timerIrq_o = mtime >= mtimecmp;

    always_comb begin
        respNext = '0;
        if (isRead) begin
            respNext.valid = 1'b1;
            respNext.src   = bus_i.src;
            case (byteAddr)
                `MMIO_MTIME_ADDR:              respNext.rdata = mtime[31:0];
                `MMIO_MTIME_ADDR + 32'd4:      respNext.rdata = mtime[63:32];
                `MMIO_MTIMECMP_ADDR:           respNext.rdata = mtimecmp[31:0];
                `MMIO_MTIMECMP_ADDR + 32'd4:   respNext.rdata = mtimecmp[63:32];
                default:                       respNext = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        resp_o <= respNext;
        if (rst) begin
            resp_o.valid <= 1'b0;
            divCnt       <= DivLast;
            mtime        <= '0;
            mtimecmp     <= '1; // Interrupt stays inactive.
        end else begin
            divCnt <= tick ? DivLast : divCnt - 1'b1;
            if (tick) mtime <= mtime + 64'd1;
            if (isWrite) begin
                case (byteAddr)
                    `MMIO_MTIME_ADDR:
                        mtime <= {mtime[63:32], mergeBytes(mtime[31:0], bus_i.req.wdata,
                                                           bus_i.req.wmask)};
                    `MMIO_MTIME_ADDR + 32'd4:
                        mtime <= {mergeBytes(mtime[63:32], bus_i.req.wdata,
                                             bus_i.req.wmask), mtime[31:0]};
                    `MMIO_MTIMECMP_ADDR:
                        mtimecmp[31:0] <= mergeBytes(mtimecmp[31:0], bus_i.req.wdata,
                                                     bus_i.req.wmask);
                    `MMIO_MTIMECMP_ADDR + 32'd4:
                        mtimecmp[63:32] <= mergeBytes(mtimecmp[63:32], bus_i.req.wdata,
                                                      bus_i.req.wmask);
                    default: ;
                endcase
            end
        end
    end

endmodule

/* source/mmioSubsystem.sv */
`include "mmio_params.svh"

module mmioSubsystem import mmio_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  busReq_t  req0_i,
    input  busReq_t  req1_i,
    output logic     accept0_o,
    output logic     accept1_o,
    output busResp_t resp0_o,
    output busResp_t resp1_o,
    output logic     timerIrq_o,
    output logic     reboot_o,
    output logic     powerOff_o,
    output logic     spiCs_o,
    output logic     spiClk_o,
    output logic     spiMosi_o,
    input  logic     spiMiso_i
);

    busSlot_t    busSlot;
    busResp_t    timerResp;
    busResp_t    spiResp;
    busResp_t    unmappedResp;
    busResp_t    mergedResp;
    logic        spiBusy;
    logic [31:0] byteAddr;
    logic        mappedRead;
    logic        unmappedValid;
    logic        unmappedSrc;

    busArbiter arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .req0_i    (req0_i),
        .req1_i    (req1_i),
        .spiBusy_i (spiBusy),
        .accept0_o (accept0_o),
        .accept1_o (accept1_o),
        .bus_o     (busSlot)
    );

    machineTimer timer_i (
        .clk        (clk),
        .rst        (rst),
        .bus_i      (busSlot),
        .resp_o     (timerResp),
        .timerIrq_o (timerIrq_o)
    );

    spiController spi_i (
        .clk       (clk),
        .rst       (rst),
        .bus_i     (busSlot),
        .resp_o    (spiResp),
        .spiBusy_o (spiBusy),
        .spiCs_o   (spiCs_o),
        .spiClk_o  (spiClk_o),
        .spiMosi_o (spiMosi_o),
        .spiMiso_i (spiMiso_i)
    );

    sysControl sysCon_i (
        .clk        (clk),
        .rst        (rst),
        .bus_i      (busSlot),
        .reboot_o   (reboot_o),
        .powerOff_o (powerOff_o)
    );

    // ********************
    // Unmapped reads
    // ********************

    assign byteAddr = {busSlot.req.addr, 2'b00};

    // System control has no read port, so its address reads as zero here too.
    assign mappedRead = (byteAddr == `MMIO_MTIME_ADDR)
                     || (byteAddr == `MMIO_MTIME_ADDR + 32'd4)
                     || (byteAddr == `MMIO_MTIMECMP_ADDR)
                     || (byteAddr == `MMIO_MTIMECMP_ADDR + 32'd4)
                     || (byteAddr == `MMIO_SPI_ADDR)
                     || (byteAddr == `MMIO_SPI_ADDR + 32'd4);

    always_ff @(posedge clk) begin
        if (rst) begin
            unmappedValid <= 1'b0;
            unmappedSrc   <= 1'b0;
        end else begin
            unmappedValid <= (busSlot.req.op == OP_READ) && !mappedRead;
            unmappedSrc   <= (busSlot.req.op == OP_READ) && !mappedRead && busSlot.src;
        end
    end

    assign unmappedResp = '{valid: unmappedValid, src: unmappedSrc, rdata: 32'b0};

    // ********************
    // Response routing
    // ********************

    assign mergedResp = busResp_t'(timerResp | spiResp | unmappedResp); // Idle peers drive zero.

    always_comb begin
        resp0_o       = mergedResp;
        resp0_o.valid = mergedResp.valid && !mergedResp.src;
        resp1_o       = mergedResp;
        resp1_o.valid = mergedResp.valid && mergedResp.src;
    end

endmodule

/* source/mmio_pkg.sv */
package mmio_pkg;

    // ********************
    // Bus types
    // ********************

    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } busOp_t;

    typedef struct packed {
        busOp_t      op;
        logic [29:0] addr; // Word address.
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } busReq_t;

    typedef struct packed {
        busReq_t req;
        logic    src; // Index of the issuing master.
    } busSlot_t;

    typedef struct packed {
        logic        valid;
        logic        src;
        logic [31:0] rdata;
    } busResp_t;

    // ********************
    // SPI engine
    // ********************

    typedef enum logic [1:0] {
        SPI_IDLE     = 2'd0,
        SPI_CLK_LOW  = 2'd1,
        SPI_CLK_HIGH = 2'd2
    } spiState_t;

endpackage

/* source/spiController.sv */
`include "mmio_params.svh"

module spiController import mmio_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  busSlot_t bus_i,
    output busResp_t resp_o,
    output logic     spiBusy_o,
    output logic     spiCs_o,
    output logic     spiClk_o,
    output logic     spiMosi_o,
    input  logic     spiMiso_i
);

    spiState_t   state;
    logic [31:0] shiftBuf; // Transmit bits leave the top, received bits enter the bottom.
    logic [5:0]  bitCnt;
    logic        rxValid;
    logic [31:0] byteAddr;
    logic        dataWrite;
    logic        dataRead;
    logic        statusRead;
    busResp_t    respNext;

    assign byteAddr   = {bus_i.req.addr, 2'b00};
    assign dataWrite  = (bus_i.req.op == OP_WRITE) && (byteAddr == `MMIO_SPI_ADDR);
    assign dataRead   = (bus_i.req.op == OP_READ) && (byteAddr == `MMIO_SPI_ADDR);
    assign statusRead = (bus_i.req.op == OP_READ) && (byteAddr == `MMIO_SPI_ADDR + 32'd4);
    assign spiBusy_o  = state != SPI_IDLE;

    always_comb begin
        respNext = '0;
        if (dataRead) begin
            respNext.valid = 1'b1;
            respNext.src   = bus_i.src;
            respNext.rdata = shiftBuf;
        end else if (statusRead) begin
            respNext.valid = 1'b1;
            respNext.src   = bus_i.src;
            respNext.rdata = {23'b0, rxValid, 7'b0, spiBusy_o};
        end
    end

    always_ff @(posedge clk) begin
        resp_o <= respNext;
        if (rst) begin
            resp_o.valid <= 1'b0;
            state        <= SPI_IDLE;
            bitCnt       <= '0;
            rxValid      <= 1'b0;
            spiCs_o      <= 1'b1;
            spiClk_o     <= 1'b0;
            spiMosi_o    <= 1'b0;
        end else begin
            if (dataRead) rxValid <= 1'b0;

            case (state)
                SPI_IDLE: begin
                    if (dataWrite) begin
                        case (bus_i.req.wmask)
                            4'b0001: begin
                                shiftBuf  <= {bus_i.req.wdata[7:0], 24'b0};
                                bitCnt    <= 6'd8;
                                spiMosi_o <= bus_i.req.wdata[7];
                            end
                            4'b0011: begin
                                shiftBuf  <= {bus_i.req.wdata[15:0], 16'b0};
                                bitCnt    <= 6'd16;
                                spiMosi_o <= bus_i.req.wdata[15];
                            end
                            default: begin
                                shiftBuf  <= bus_i.req.wdata;
                                bitCnt    <= 6'd32;
                                spiMosi_o <= bus_i.req.wdata[31];
                            end
                        endcase
                        spiCs_o <= 1'b0;
                        state   <= SPI_CLK_LOW;
                    end
                end
                SPI_CLK_LOW: begin
                    spiClk_o <= 1'b1;
                    shiftBuf <= {shiftBuf[30:0], spiMiso_i}; // Sample on the rising SPI clock.
                    state    <= SPI_CLK_HIGH;
                end
                SPI_CLK_HIGH: begin
                    spiClk_o <= 1'b0;
                    bitCnt   <= bitCnt - 6'd1;
                    if (bitCnt == 6'd1) begin
                        spiCs_o <= 1'b1;
                        rxValid <= 1'b1;
                        state   <= SPI_IDLE;
                    end else begin
                        spiMosi_o <= shiftBuf[31];
                        state     <= SPI_CLK_LOW;
                    end
                end
                default: state <= SPI_IDLE;
            endcase
        end
    end

endmodule

/* source/sysControl.sv */
`include "mmio_params.svh"

module sysControl import mmio_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  busSlot_t bus_i,
    output logic     reboot_o,
    output logic     powerOff_o
);

    logic sysWrite;

    assign sysWrite = (bus_i.req.op == OP_WRITE)
                   && ({bus_i.req.addr, 2'b00} == `MMIO_SYSCON_ADDR)
                   && bus_i.req.wmask[0];

    // Both outputs are single-cycle pulses.
    always_ff @(posedge clk) begin
        if (rst) begin
            reboot_o   <= 1'b0;
            powerOff_o <= 1'b0;
        end else begin
            reboot_o   <= sysWrite && (bus_i.req.wdata[7:0] == 8'h77);
            powerOff_o <= sysWrite && (bus_i.req.wdata[7:0] == 8'h55);
        end
    end

endmodule
